/* hdl/exec_pkg.sv */
package exec_pkg;

    // Vector geometry
    localparam int NUM_LANES = 4;
    localparam int SCALAR_WIDTH = 32;

    // Derived widths
    localparam int LANE_IDX_WIDTH = $clog2(NUM_LANES);
    localparam int THREAD_IDX_WIDTH = 2;
    localparam int SHIFT_AMT_WIDTH = $clog2(SCALAR_WIDTH);

    // Zero count needs one extra bit so that an all-zero word reads as 32
    localparam int BIT_COUNT_WIDTH = $clog2(SCALAR_WIDTH) + 1;

    // One lane value
    typedef logic [SCALAR_WIDTH-1:0] scalar_t;

    // Element 0 sits in the least significant word
    typedef scalar_t [NUM_LANES-1:0] vector_t;

    // One enable bit per lane
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // Selects one element of a vector
    typedef logic [LANE_IDX_WIDTH-1:0] lane_idx_t;

    // Hardware thread number
    typedef logic [THREAD_IDX_WIDTH-1:0] thread_idx_t;

    // Only the low bits of operand2 count for shifts
    typedef logic [SHIFT_AMT_WIDTH-1:0] shift_amt_t;

    // Leading or trailing zero count, 0 to 32
    typedef logic [BIT_COUNT_WIDTH-1:0] bit_count_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

    // Integer operations handled by the lane ALUs
    typedef enum logic [5:0] {
        OP_OR,
        OP_AND,
        OP_XOR,
        OP_ADD_I,
        OP_SUB_I,
        OP_ASHR,
        OP_SHR,
        OP_SHL,
        OP_CLZ,
        OP_CTZ,
        OP_MOVE,
        OP_SEXT8,
        OP_SEXT16,
        OP_SHUFFLE,
        OP_GETLANE,
        OP_CMPEQ_I,
        OP_CMPNE_I,
        OP_CMPGT_I,
        OP_CMPGE_I,
        OP_CMPLT_I,
        OP_CMPLE_I,
        OP_CMPGT_U,
        OP_CMPGE_U,
        OP_CMPLT_U,
        OP_CMPLE_U
    } alu_op_t;

    typedef enum logic [2:0] {
        BRANCH_ZERO,
        BRANCH_NOT_ZERO,
        BRANCH_ALWAYS,
        BRANCH_CALL_OFFSET,
        BRANCH_CALL_REGISTER,
        BRANCH_REGISTER
    } branch_type_t;

    // Which execution pipe owns the instruction
    typedef enum logic {
        PIPE_INT_ARITH,
        PIPE_OTHER
    } pipeline_sel_t;

    typedef struct packed {
        exec_pkg::scalar_t pc;
        exec_pkg::scalar_t immediate_value;
        alu_op_t alu_op;
        logic is_branch;
        branch_type_t branch_type;
        pipeline_sel_t pipeline_sel;
        logic [4:0] dest_reg;
    } decoded_instruction_t;

    // Registered stage output towards writeback
    typedef struct packed {
        decoded_instruction_t instruction;
        exec_pkg::vector_t result;
        exec_pkg::lane_mask_t mask_value;
        exec_pkg::thread_idx_t thread_idx;
    } ix_result_t;

endpackage

/* hdl/zero_count.sv */
`timescale 1ns/100ps

module zero_count (
    input exec_pkg::scalar_t value,
    output exec_pkg::bit_count_t leading,
    output exec_pkg::bit_count_t trailing
);
    import exec_pkg::*;

    // Scan upwards so the highest set bit wins
    always_comb
    begin
        leading = bit_count_t'(SCALAR_WIDTH);
        for (int i = 0; i < SCALAR_WIDTH; i++)
        begin
            if (value[i])
                leading = bit_count_t'(SCALAR_WIDTH - 1 - i);
        end
    end

    // Scan downwards so the lowest set bit wins
    always_comb
    begin
        trailing = bit_count_t'(SCALAR_WIDTH);
        for (int i = SCALAR_WIDTH - 1; i >= 0; i--)
        begin
            if (value[i])
                trailing = bit_count_t'(i);
        end
    end

endmodule

/* hdl/int_lane_alu.sv */
`timescale 1ns/100ps

module int_lane_alu #(
    parameter int LANE = 0
) (
    input isa_pkg::alu_op_t alu_op,
    input exec_pkg::vector_t operand1_vec,
    input exec_pkg::scalar_t operand2,
    output exec_pkg::scalar_t lane_result
);
    import exec_pkg::*;
    import isa_pkg::*;

    scalar_t operand1;
    scalar_t difference;
    logic borrow;
    logic negative;
    logic overflow;
    logic zero;
    logic signed_gtr;
    shift_amt_t shift_amt;
    logic shift_in_sign;
    scalar_t right_shift;
    bit_count_t leading;
    bit_count_t trailing;
    lane_idx_t src_lane;

    assign operand1 = operand1_vec[LANE];

    // Compare flags all come from a single subtraction
    assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
    assign negative = difference[SCALAR_WIDTH-1];
    assign overflow = operand2[SCALAR_WIDTH-1] == negative
        && operand1[SCALAR_WIDTH-1] != operand2[SCALAR_WIDTH-1];
    assign zero = difference == '0;
    assign signed_gtr = overflow == negative;

    assign shift_amt = shift_amt_t'(operand2);
    assign shift_in_sign = alu_op == OP_ASHR ? operand1[SCALAR_WIDTH-1] : 1'b0;
    assign right_shift = scalar_t'({{SCALAR_WIDTH{shift_in_sign}}, operand1} >> shift_amt);

    // Lane 0 maps to the top element
    assign src_lane = lane_idx_t'(NUM_LANES - 1) - lane_idx_t'(operand2);

    zero_count zero_count_inst (
        .value(operand2),
        .leading(leading),
        .trailing(trailing)
    );

    always_comb
    begin
        case (alu_op)
            OP_OR: lane_result = operand1 | operand2;
            OP_AND: lane_result = operand1 & operand2;
            OP_XOR: lane_result = operand1 ^ operand2;
            OP_ADD_I: lane_result = operand1 + operand2;
            OP_SUB_I: lane_result = difference;
            OP_ASHR,
            OP_SHR: lane_result = right_shift;
            OP_SHL: lane_result = operand1 << shift_amt;
            OP_CLZ: lane_result = scalar_t'(leading);
            OP_CTZ: lane_result = scalar_t'(trailing);
            OP_MOVE: lane_result = operand2;
            OP_SEXT8: lane_result = scalar_t'($signed(operand2[7:0]));
            OP_SEXT16: lane_result = scalar_t'($signed(operand2[15:0]));
            OP_SHUFFLE,
            OP_GETLANE: lane_result = operand1_vec[src_lane];
            OP_CMPEQ_I: lane_result = scalar_t'(zero);
            OP_CMPNE_I: lane_result = scalar_t'(!zero);
            OP_CMPGT_I: lane_result = scalar_t'(signed_gtr && !zero);
            OP_CMPGE_I: lane_result = scalar_t'(signed_gtr || zero);
            OP_CMPLT_I: lane_result = scalar_t'(!signed_gtr && !zero);
            OP_CMPLE_I: lane_result = scalar_t'(!signed_gtr || zero);
            OP_CMPGT_U: lane_result = scalar_t'(!borrow && !zero);
            OP_CMPGE_U: lane_result = scalar_t'(!borrow || zero);
            OP_CMPLT_U: lane_result = scalar_t'(borrow && !zero);
            OP_CMPLE_U: lane_result = scalar_t'(borrow || zero);
            default: lane_result = '0;
        endcase
    end

endmodule

/* hdl/branch_resolve.sv */
`timescale 1ns/100ps

module branch_resolve (
    input logic of_instruction_valid,
    input isa_pkg::decoded_instruction_t of_instruction,
    input exec_pkg::vector_t of_operand1,
    output logic is_valid_instruction,
    output logic branch_taken,
    output exec_pkg::scalar_t rollback_pc_next
);
    import exec_pkg::*;
    import isa_pkg::*;

    scalar_t test_value;

    // Conditions and register targets come from lane 0
    assign test_value = of_operand1[0];

    assign is_valid_instruction = of_instruction_valid
        && of_instruction.pipeline_sel == PIPE_INT_ARITH;

    always_comb
    begin
        branch_taken = 1'b0;
        if (is_valid_instruction && of_instruction.is_branch)
        begin
            case (of_instruction.branch_type)
                BRANCH_ZERO: branch_taken = !test_value[0];
                BRANCH_NOT_ZERO: branch_taken = test_value[0];
                BRANCH_ALWAYS,
                BRANCH_CALL_OFFSET,
                BRANCH_CALL_REGISTER,
                BRANCH_REGISTER: branch_taken = 1'b1;
                default: branch_taken = 1'b0;
            endcase
        end
    end

    // Register branches jump through lane 0, all others are pc relative
    always_comb
    begin
        case (of_instruction.branch_type)
            BRANCH_CALL_REGISTER,
            BRANCH_REGISTER: rollback_pc_next = test_value;
            default: rollback_pc_next = of_instruction.pc + of_instruction.immediate_value;
        endcase
    end

endmodule

/* hdl/execute_result_reg.sv */
`timescale 1ns/100ps

module execute_result_reg (
    input logic clk,
    input logic reset,
    input logic is_valid_instruction,
    input logic branch_taken,
    input exec_pkg::scalar_t rollback_pc_next,
    input exec_pkg::vector_t vector_result,
    input isa_pkg::decoded_instruction_t of_instruction,
    input exec_pkg::lane_mask_t of_mask_value,
    input exec_pkg::thread_idx_t of_thread_idx,
    output logic ix_instruction_valid,
    output isa_pkg::ix_result_t ix_result,
    output logic ix_rollback_en,
    output exec_pkg::scalar_t ix_rollback_pc
);

    // Payload, only meaningful while valid is high
    always_ff @(posedge clk)
    begin
        ix_result.instruction <= of_instruction;
        ix_result.result <= vector_result;
        ix_result.mask_value <= of_mask_value;
        ix_result.thread_idx <= of_thread_idx;
        ix_rollback_pc <= rollback_pc_next;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ix_instruction_valid <= 1'b0;
            ix_rollback_en <= 1'b0;
        end
        else
        begin
            ix_instruction_valid <= is_valid_instruction;
            ix_rollback_en <= branch_taken;
        end
    end

    // A rollback must come with a valid instruction
    rollback_needs_valid: assert property (@(posedge clk) disable iff (reset)
        ix_rollback_en |-> ix_instruction_valid);

endmodule

/* hdl/int_execute_stage.sv */
`timescale 1ns/100ps

module int_execute_stage (
    input logic clk,
    input logic reset,

    // From operand fetch
    input logic of_instruction_valid,
    input isa_pkg::decoded_instruction_t of_instruction,
    input exec_pkg::vector_t of_operand1,
    input exec_pkg::vector_t of_operand2,
    input exec_pkg::lane_mask_t of_mask_value,
    input exec_pkg::thread_idx_t of_thread_idx,

    // To writeback
    output logic ix_instruction_valid,
    output isa_pkg::ix_result_t ix_result,
    output logic ix_rollback_en,
    output exec_pkg::scalar_t ix_rollback_pc
);
    import exec_pkg::*;

    logic is_valid_instruction;
    logic branch_taken;
    scalar_t rollback_pc_next;
    vector_t vector_result;

    branch_resolve branch_resolve_inst (
        .of_instruction_valid(of_instruction_valid),
        .of_instruction(of_instruction),
        .of_operand1(of_operand1),
        .is_valid_instruction(is_valid_instruction),
        .branch_taken(branch_taken),
        .rollback_pc_next(rollback_pc_next)
    );

    // One ALU per vector lane
    for (genvar lane = 0; lane < NUM_LANES; lane++)
    begin : lane_alu_gen
        int_lane_alu #(
            .LANE(lane)
        ) lane_alu (
            .alu_op(of_instruction.alu_op),
            .operand1_vec(of_operand1),
            .operand2(of_operand2[lane]),
            .lane_result(vector_result[lane])
        );
    end

    execute_result_reg result_reg (
        .clk(clk),
        .reset(reset),
        .is_valid_instruction(is_valid_instruction),
        .branch_taken(branch_taken),
        .rollback_pc_next(rollback_pc_next),
        .vector_result(vector_result),
        .of_instruction(of_instruction),
        .of_mask_value(of_mask_value),
        .of_thread_idx(of_thread_idx),
        .ix_instruction_valid(ix_instruction_valid),
        .ix_result(ix_result),
        .ix_rollback_en(ix_rollback_en),
        .ix_rollback_pc(ix_rollback_pc)
    );

endmodule

/* testbench/tb_int_execute_stage.sv */
`timescale 1ns/100ps

module tb_int_execute_stage;
    import exec_pkg::*;
    import isa_pkg::*;

    logic clk;
    logic reset;
    logic of_instruction_valid;
    decoded_instruction_t of_instruction;
    vector_t of_operand1;
    vector_t of_operand2;
    lane_mask_t of_mask_value;
    thread_idx_t of_thread_idx;
    logic ix_instruction_valid;
    ix_result_t ix_result;
    logic ix_rollback_en;
    scalar_t ix_rollback_pc;
    int errors;
    integer seed;

    int_execute_stage UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Expected value of one lane, straight from the operation definitions
    function automatic scalar_t expected_lane(alu_op_t op, vector_t a, vector_t b, int lane);
        scalar_t x = a[lane];
        scalar_t y = b[lane];
        int n = 0;
        case (op)
            OP_OR: return x | y;
            OP_AND: return x & y;
            OP_XOR: return x ^ y;
            OP_ADD_I: return x + y;
            OP_SUB_I: return x - y;
            OP_ASHR: return $signed(x) >>> y[4:0];
            OP_SHR: return x >> y[4:0];
            OP_SHL: return x << y[4:0];
            // Counts are taken on the second operand
            OP_CLZ:
                while (n < 32 && y[31 - n] == 1'b0)
                    n++;
            OP_CTZ:
                while (n < 32 && y[n] == 1'b0)
                    n++;
            OP_MOVE: return y;
            OP_SEXT8: return {{24{y[7]}}, y[7:0]};
            OP_SEXT16: return {{16{y[15]}}, y[15:0]};
            // Lane 0 reads the top element
            OP_SHUFFLE,
            OP_GETLANE: return a[NUM_LANES - 1 - int'(y % NUM_LANES)];
            OP_CMPEQ_I: return scalar_t'(x == y);
            OP_CMPNE_I: return scalar_t'(x != y);
            OP_CMPGT_I: return scalar_t'($signed(x) > $signed(y));
            OP_CMPGE_I: return scalar_t'($signed(x) >= $signed(y));
            OP_CMPLT_I: return scalar_t'($signed(x) < $signed(y));
            OP_CMPLE_I: return scalar_t'($signed(x) <= $signed(y));
            OP_CMPGT_U: return scalar_t'(x > y);
            OP_CMPGE_U: return scalar_t'(x >= y);
            OP_CMPLT_U: return scalar_t'(x < y);
            OP_CMPLE_U: return scalar_t'(x <= y);
            default: return '0;
        endcase
        return scalar_t'(n);
    endfunction

    task automatic report_error(string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    // Issue one instruction on the falling edge and check it one clock later
    task automatic run_instruction(alu_op_t op, pipeline_sel_t pipe, logic branch,
                                   branch_type_t bt, vector_t a, vector_t b);
        scalar_t expected;
        scalar_t target;
        logic taken;
        of_instruction_valid = 1'b1;
        of_instruction.pc = $random(seed);
        of_instruction.immediate_value = $random(seed);
        of_instruction.alu_op = op;
        of_instruction.is_branch = branch;
        of_instruction.branch_type = bt;
        of_instruction.pipeline_sel = pipe;
        of_instruction.dest_reg = 5'($random(seed));
        of_operand1 = a;
        of_operand2 = b;
        of_mask_value = lane_mask_t'($random(seed));
        of_thread_idx = thread_idx_t'($random(seed));
        // Zero tests look at bit 0 of lane 0, every other type jumps
        taken = pipe == PIPE_INT_ARITH && branch
            && (bt == BRANCH_ZERO ? !a[0][0] : bt == BRANCH_NOT_ZERO ? a[0][0] : 1'b1);
        target = (bt == BRANCH_CALL_REGISTER || bt == BRANCH_REGISTER) ? a[0]
            : of_instruction.pc + of_instruction.immediate_value;
        @(posedge clk);
        @(negedge clk);
        if (ix_instruction_valid !== (pipe == PIPE_INT_ARITH) || ix_rollback_en !== taken)
            report_error($sformatf("%s %s: valid %b, rollback %b", op.name(), bt.name(),
                ix_instruction_valid, ix_rollback_en));
        if (taken && ix_rollback_pc !== target)
            report_error($sformatf("%s: rollback pc %h, expected %h", bt.name(),
                ix_rollback_pc, target));
        for (int k = 0; k < NUM_LANES; k++)
        begin
            expected = expected_lane(op, a, b, k);
            if (pipe == PIPE_INT_ARITH && ix_result.result[k] !== expected)
                report_error($sformatf("%s lane %0d: got %h, expected %h", op.name(), k,
                    ix_result.result[k], expected));
        end
        if (ix_result.mask_value !== of_mask_value || ix_result.thread_idx !== of_thread_idx)
            report_error("mask or thread index did not pass through unchanged");
        if (ix_result.instruction !== of_instruction)
            report_error($sformatf("instruction field %h, expected %h",
                ix_result.instruction, of_instruction));
    endtask

    task automatic check_reset_state();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (ix_instruction_valid !== 1'b0 || ix_rollback_en !== 1'b0)
            report_error("valid or rollback set right after reset");
    endtask

    // Every ALU operation on random operands, then on the edge pairs both ways round
    task automatic sweep_alu_ops();
        vector_t a;
        vector_t b;
        repeat (8)
        begin
            a = {$random(seed), $random(seed), $random(seed), $random(seed)};
            b = {$random(seed), $random(seed), $random(seed), $random(seed)};
            for (int o = OP_OR; o <= OP_CMPLE_U; o++)
                run_instruction(alu_op_t'(o), PIPE_INT_ARITH, 1'b0, BRANCH_ALWAYS, a, b);
        end
        // Lane 0 equal, then sign boundary, all ones against zero
        a = {32'h00000001, 32'hffffffff, 32'h80000000, 32'h5a5a0ff0};
        b = {32'h80000000, 32'h00000000, 32'h00000001, 32'h5a5a0ff0};
        for (int o = OP_OR; o <= OP_CMPLE_U; o++)
        begin
            run_instruction(alu_op_t'(o), PIPE_INT_ARITH, 1'b0, BRANCH_ALWAYS, a, b);
            run_instruction(alu_op_t'(o), PIPE_INT_ARITH, 1'b0, BRANCH_ALWAYS, b, a);
        end
    endtask

    // Issued in consecutive cycles, so each result also shows the one-cycle latency
    task automatic exercise_branches();
        vector_t a;
        vector_t b;
        for (int t = BRANCH_ZERO; t <= BRANCH_REGISTER; t++)
        begin
            a = {$random(seed), $random(seed), $random(seed), $random(seed)};
            b = {$random(seed), $random(seed), $random(seed), $random(seed)};
            run_instruction(OP_MOVE, PIPE_INT_ARITH, 1'b1, branch_type_t'(t), a, b);
            a[0][0] = !a[0][0];
            run_instruction(OP_MOVE, PIPE_INT_ARITH, 1'b1, branch_type_t'(t), a, b);
            run_instruction(OP_MOVE, PIPE_INT_ARITH, 1'b0, branch_type_t'(t), a, b);
        end
        // Owned by another pipe
        run_instruction(OP_ADD_I, PIPE_OTHER, 1'b1, BRANCH_ALWAYS, a, b);
    endtask

    initial
    begin
        seed = 32'h1cdd9bba;
        errors = 0;
        reset = 1'b1;
        of_instruction_valid = 1'b0;
        of_instruction = '0;
        of_operand1 = '0;
        of_operand2 = '0;
        of_mask_value = '0;
        of_thread_idx = '0;
        check_reset_state();
        sweep_alu_ops();
        exercise_branches();
        $display("Tests done with %0d errors", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* vlog.f */
hdl/exec_pkg.sv
hdl/isa_pkg.sv
hdl/zero_count.sv
hdl/int_lane_alu.sv
hdl/branch_resolve.sv
hdl/execute_result_reg.sv
hdl/int_execute_stage.sv
testbench/tb_int_execute_stage.sv

/* run_sim.sh */
#!/bin/bash
# Build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_int_execute_stage \
    -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || { echo "Simulation build or run failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
